//--- common/bench_settings.svh
// ==================================================
// tcp benchmark role widths
// stream, message and counter sizes in bits
// ==================================================
`ifndef BENCH_SETTINGS_SVH
`define BENCH_SETTINGS_SVH

// data path toward the stack
`define BENCH_DATA_W 64 // stream data
`define BENCH_KEEP_W (`BENCH_DATA_W / 8) // one keep bit per byte

// message fields
`define BENCH_SESSION_W 16 // session id
`define BENCH_PORT_W 16 // tcp port
`define BENCH_IP_W 32 // ipv4 address
`define BENCH_OPEN_STS_W 24 // open status word
`define BENCH_TX_STS_W 64 // tx status word

// statistics
`define BENCH_CNT_W 64 // bytes and cycles
`define BENCH_EVT_W 32 // packets and replies

`endif

//--- common/tcp_msg_pkg.sv
// ==================================================
// tcp stack message formats
// open request, open status and tx status words
// ==================================================
`include "bench_settings.svh"

package tcp_msg_pkg;

	localparam int TX_ERR_W = 2; // error code at top of tx status
	localparam int OPEN_RSVD_W = `BENCH_OPEN_STS_W - 1 - `BENCH_SESSION_W; // unused high bits

	typedef logic [`BENCH_SESSION_W-1:0] session_t;

	// open connection request, port above address
	typedef struct packed {
		logic [`BENCH_PORT_W-1:0] port; // remote port
		logic [`BENCH_IP_W-1:0] ip; // remote ipv4
	} open_req_t;

	// reply to an open request
	typedef struct packed {
		logic [OPEN_RSVD_W-1:0] rsvd; // ignored
		logic success; // bit 16
		session_t session; // valid only with success
	} open_status_t;

	// reply per transmitted segment
	typedef struct packed {
		logic [TX_ERR_W-1:0] error; // zero means good
		logic [`BENCH_TX_STS_W-TX_ERR_W-1:0] info; // length, remaining space, session
	} tx_status_t;

endpackage

//--- common/bench_pkg.sv
// ==================================================
// benchmark statistics types
// byte, cycle and event counters, transfer size
// ==================================================
`include "bench_settings.svh"

package bench_pkg;

	typedef logic [`BENCH_CNT_W-1:0] byte_count_t; // consumed or produced bytes
	typedef logic [`BENCH_CNT_W-1:0] cycle_count_t; // execution and setup time
	typedef logic [`BENCH_EVT_W-1:0] event_count_t; // packets, replies, opens

	// bytes per direction before the run ends
	typedef logic [`BENCH_EVT_W-1:0] xfer_size_t;

endpackage

//--- common/beat_tap_if.sv
// ==================================================
// beat tap
// observed copy of one data stream handshake
// ==================================================
`timescale 1ns/1ps
`include "bench_settings.svh"

interface beat_tap_if;

	logic valid; // source has a beat
	logic ready; // sink takes it
	logic [`BENCH_KEEP_W-1:0] keep; // byte enables, low aligned
	logic last; // end of packet

	// watch only, never drives the stream
	modport mon (
		input valid,
		input ready,
		input keep,
		input last
	);

endinterface

//--- hdl/byte_meter.sv
// ==================================================
// byte meter
// counts bytes and packets of accepted beats
// ==================================================
`timescale 1ns/1ps
`include "bench_settings.svh"

module byte_meter (
	input logic ap_clk,
	input logic ap_rst_n,
	input logic start_pulse, // new run, clear counts
	beat_tap_if.mon tap,
	output bench_pkg::byte_count_t byte_count,
	output bench_pkg::event_count_t pkt_count
);

	localparam int BEAT_BYTES_W = $clog2(`BENCH_KEEP_W + 1); // room for a full beat

	logic beat_acc; // beat handshake this cycle
	logic [BEAT_BYTES_W-1:0] beat_bytes; // bytes carried by the beat

	// number of enabled bytes
	function automatic logic [BEAT_BYTES_W-1:0] keep_bytes(
		input logic [`BENCH_KEEP_W-1:0] keep
	);
		logic [BEAT_BYTES_W-1:0] n;
		n = '0;
		for (int i = 0; i < `BENCH_KEEP_W; i++) begin
			n = n + keep[i];
		end
		return n;
	endfunction

	assign beat_acc = tap.valid & tap.ready;
	assign beat_bytes = keep_bytes(tap.keep);

	always_ff @(posedge ap_clk) begin
		if (!ap_rst_n) begin
			byte_count <= '0;
			pkt_count <= '0;
		end else if (start_pulse) begin
			byte_count <= '0; // start wins over a beat in the same cycle
			pkt_count <= '0;
		end else if (beat_acc) begin
			byte_count <= byte_count + bench_pkg::byte_count_t'(beat_bytes);
			if (tap.last) begin
				pkt_count <= pkt_count + 1'b1; // one per packet end
			end
		end
	end

endmodule

//--- status/conn_status_tracker.sv
// ==================================================
// connection status tracker
// session id from open status or rx metadata,
// counts of opens and tx status replies
// ==================================================
`timescale 1ns/1ps

module conn_status_tracker (
	input logic ap_clk,
	input logic ap_rst_n,
	input logic start_pulse, // clears all state
	input logic running,
	input logic is_server,
	// open status from the stack
	input logic open_status_tvalid,
	input logic open_status_tready,
	input tcp_msg_pkg::open_status_t open_status_tdata,
	// rx metadata, session of incoming data
	input logic rx_meta_tvalid,
	input logic rx_meta_tready,
	input tcp_msg_pkg::session_t rx_meta_tdata,
	// tx status replies
	input logic tx_status_tvalid,
	input logic tx_status_tready,
	input tcp_msg_pkg::tx_status_t tx_status_tdata,
	output logic open_ok, // accepted successful open, one cycle
	output bench_pkg::event_count_t open_ok_count,
	output tcp_msg_pkg::session_t session_id,
	output bench_pkg::event_count_t tx_sts_count,
	output bench_pkg::event_count_t tx_sts_good_count
);

	logic open_acc; // open status beat taken
	logic meta_acc; // rx meta beat taken
	logic sts_acc; // tx status beat taken
	logic sts_good; // no error code

	assign open_acc = open_status_tvalid & open_status_tready;
	assign meta_acc = rx_meta_tvalid & rx_meta_tready;
	assign sts_acc = tx_status_tvalid & tx_status_tready;
	assign sts_good = (tx_status_tdata.error == '0);

	assign open_ok = open_acc & open_status_tdata.success; // failures are dropped

	always_ff @(posedge ap_clk) begin
		if (!ap_rst_n) begin
			session_id <= '0;
			open_ok_count <= '0;
			tx_sts_count <= '0;
			tx_sts_good_count <= '0;
		end else if (start_pulse) begin
			session_id <= '0;
			open_ok_count <= '0;
			tx_sts_count <= '0;
			tx_sts_good_count <= '0;
		end else begin
			// session source follows the role
			if (running & is_server & meta_acc) begin
				session_id <= rx_meta_tdata; // server learns it from the peer
			end else if (running & ~is_server & open_ok) begin
				session_id <= open_status_tdata.session; // client gets it from the stack
			end

			if (open_ok) begin
				open_ok_count <= open_ok_count + 1'b1;
			end

			if (sts_acc) begin
				tx_sts_count <= tx_sts_count + 1'b1;
				if (sts_good) begin
					tx_sts_good_count <= tx_sts_good_count + 1'b1;
				end
			end
		end
	end

endmodule

//--- control/experiment_ctrl.sv
// ==================================================
// experiment controller
// start edge, run state, open request, run_tx
// and the execution and setup cycle counters
// ==================================================
`timescale 1ns/1ps
`include "bench_settings.svh"

module experiment_ctrl (
	input logic ap_clk,
	input logic ap_rst_n,
	input logic ap_start,
	input logic is_server,
	input bench_pkg::xfer_size_t transfer_size,
	input logic [`BENCH_IP_W-1:0] base_ip,
	input logic [`BENCH_PORT_W-1:0] base_port,
	input logic open_conn_tready,
	input logic open_ok, // successful open this cycle
	input bench_pkg::event_count_t open_ok_count,
	input bench_pkg::byte_count_t consumed_bytes,
	input bench_pkg::byte_count_t produced_bytes,
	output logic start_pulse,
	output logic running,
	output logic ap_done,
	output logic ap_idle,
	output logic open_conn_tvalid,
	output tcp_msg_pkg::open_req_t open_conn_tdata,
	output logic run_tx, // one cycle go for the traffic core
	output bench_pkg::cycle_count_t execution_cycles,
	output bench_pkg::cycle_count_t open_con_cycles
);

	logic ap_start_r; // ap_start one cycle back
	logic req_accepted; // stack took this run's open request
	logic sent_run_tx; // run_tx already fired this run
	logic rx_full; // enough bytes received
	logic tx_full; // enough bytes sent
	logic finish; // last running cycle
	logic tx_go; // mode condition for run_tx
	bench_pkg::byte_count_t xfer_bytes; // transfer size widened

	assign start_pulse = ap_start & ~ap_start_r; // rising edge only

	// client asks once per run, no retry
	assign open_conn_tvalid = start_pulse & ~is_server;
	assign open_conn_tdata.port = base_port;
	assign open_conn_tdata.ip = base_ip;

	assign xfer_bytes = bench_pkg::byte_count_t'(transfer_size);
	assign rx_full = (consumed_bytes >= xfer_bytes);
	assign tx_full = (produced_bytes >= xfer_bytes);
	assign finish = running & rx_full & tx_full;

	// server sends back after the peer's data, client after its open
	assign tx_go = is_server ? rx_full : (open_ok & req_accepted);

	always_ff @(posedge ap_clk) begin
		if (!ap_rst_n) begin
			ap_start_r <= 1'b0;
		end else begin
			ap_start_r <= ap_start;
		end
	end

	// run state and completion flags
	always_ff @(posedge ap_clk) begin
		if (!ap_rst_n) begin
			running <= 1'b0;
			ap_done <= 1'b0;
			ap_idle <= 1'b1; // idle out of reset
			req_accepted <= 1'b0;
		end else if (start_pulse) begin
			running <= 1'b1;
			ap_done <= 1'b0;
			ap_idle <= 1'b0;
			req_accepted <= open_conn_tvalid & open_conn_tready; // lost if not ready
		end else if (finish) begin
			running <= 1'b0;
			ap_done <= 1'b1; // held until next start
			ap_idle <= 1'b1;
		end
	end

	// single run_tx per run
	always_ff @(posedge ap_clk) begin
		if (!ap_rst_n) begin
			run_tx <= 1'b0;
			sent_run_tx <= 1'b0;
		end else if (start_pulse) begin
			run_tx <= 1'b0;
			sent_run_tx <= 1'b0;
		end else if (running & tx_go & ~sent_run_tx) begin
			run_tx <= 1'b1;
			sent_run_tx <= 1'b1; // blocks a second pulse next cycle
		end else begin
			run_tx <= 1'b0;
		end
	end

	// cycle counters
	always_ff @(posedge ap_clk) begin
		if (!ap_rst_n) begin
			execution_cycles <= '0;
			open_con_cycles <= '0;
		end else if (start_pulse) begin
			execution_cycles <= '0;
			open_con_cycles <= '0;
		end else if (running) begin
			execution_cycles <= execution_cycles + 1'b1;
			if (open_ok_count == '0) begin
				open_con_cycles <= open_con_cycles + 1'b1; // still waiting on setup
			end
		end
	end

endmodule

//--- hdl/tcp_bench_role.sv
// ==================================================
// tcp send/receive benchmark role
// watches the traffic core streams, runs one
// experiment per ap_start and reports statistics
// ==================================================
`timescale 1ns/1ps
`include "bench_settings.svh"

module tcp_bench_role (
	input logic ap_clk,
	input logic ap_rst_n,
	input logic ap_start,
	input logic is_server,
	input bench_pkg::xfer_size_t transfer_size,
	input logic [`BENCH_IP_W-1:0] base_ip,
	input logic [`BENCH_PORT_W-1:0] base_port,
	output logic ap_done,
	output logic ap_idle,
	// open connection request
	output logic open_conn_tvalid,
	input logic open_conn_tready,
	output tcp_msg_pkg::open_req_t open_conn_tdata,
	// open status
	input logic open_status_tvalid,
	output logic open_status_tready,
	input tcp_msg_pkg::open_status_t open_status_tdata,
	// rx metadata
	input logic rx_meta_tvalid,
	input logic rx_meta_tready,
	input tcp_msg_pkg::session_t rx_meta_tdata,
	// rx data, observed only
	input logic rx_data_tvalid,
	input logic rx_data_tready,
	input logic [`BENCH_KEEP_W-1:0] rx_data_tkeep,
	input logic rx_data_tlast,
	// tx data, observed only
	input logic tx_data_tvalid,
	input logic tx_data_tready,
	input logic [`BENCH_KEEP_W-1:0] tx_data_tkeep,
	input logic tx_data_tlast,
	// tx status
	input logic tx_status_tvalid,
	input logic tx_status_tready,
	input tcp_msg_pkg::tx_status_t tx_status_tdata,
	// results
	output logic run_tx,
	output tcp_msg_pkg::session_t session_id,
	output bench_pkg::byte_count_t consumed_bytes,
	output bench_pkg::byte_count_t produced_bytes,
	output bench_pkg::event_count_t rx_pkt_count,
	output bench_pkg::event_count_t tx_pkt_count,
	output bench_pkg::cycle_count_t execution_cycles,
	output bench_pkg::cycle_count_t open_con_cycles,
	output bench_pkg::event_count_t tx_sts_count,
	output bench_pkg::event_count_t tx_sts_good_count
);

	logic start_pulse; // run begins
	logic running;
	logic open_ok; // successful open accepted
	bench_pkg::event_count_t open_ok_count;

	beat_tap_if rx_tap ();
	beat_tap_if tx_tap ();

	assign open_status_tready = 1'b1; // open replies always taken

	assign rx_tap.valid = rx_data_tvalid;
	assign rx_tap.ready = rx_data_tready;
	assign rx_tap.keep = rx_data_tkeep;
	assign rx_tap.last = rx_data_tlast;

	assign tx_tap.valid = tx_data_tvalid;
	assign tx_tap.ready = tx_data_tready;
	assign tx_tap.keep = tx_data_tkeep;
	assign tx_tap.last = tx_data_tlast;

	conn_status_tracker u_tracker (
		.ap_clk (ap_clk),
		.ap_rst_n (ap_rst_n),
		.start_pulse (start_pulse),
		.running (running),
		.is_server (is_server),
		.open_status_tvalid (open_status_tvalid),
		.open_status_tready (open_status_tready),
		.open_status_tdata (open_status_tdata),
		.rx_meta_tvalid (rx_meta_tvalid),
		.rx_meta_tready (rx_meta_tready),
		.rx_meta_tdata (rx_meta_tdata),
		.tx_status_tvalid (tx_status_tvalid),
		.tx_status_tready (tx_status_tready),
		.tx_status_tdata (tx_status_tdata),
		.open_ok (open_ok),
		.open_ok_count (open_ok_count),
		.session_id (session_id),
		.tx_sts_count (tx_sts_count),
		.tx_sts_good_count (tx_sts_good_count)
	);

	experiment_ctrl u_ctrl (
		.ap_clk (ap_clk),
		.ap_rst_n (ap_rst_n),
		.ap_start (ap_start),
		.is_server (is_server),
		.transfer_size (transfer_size),
		.base_ip (base_ip),
		.base_port (base_port),
		.open_conn_tready (open_conn_tready),
		.open_ok (open_ok),
		.open_ok_count (open_ok_count),
		.consumed_bytes (consumed_bytes),
		.produced_bytes (produced_bytes),
		.start_pulse (start_pulse),
		.running (running),
		.ap_done (ap_done),
		.ap_idle (ap_idle),
		.open_conn_tvalid (open_conn_tvalid),
		.open_conn_tdata (open_conn_tdata),
		.run_tx (run_tx),
		.execution_cycles (execution_cycles),
		.open_con_cycles (open_con_cycles)
	);

	// received side
	byte_meter u_rx_meter (
		.ap_clk (ap_clk),
		.ap_rst_n (ap_rst_n),
		.start_pulse (start_pulse),
		.tap (rx_tap.mon),
		.byte_count (consumed_bytes),
		.pkt_count (rx_pkt_count)
	);

	// produced side
	byte_meter u_tx_meter (
		.ap_clk (ap_clk),
		.ap_rst_n (ap_rst_n),
		.start_pulse (start_pulse),
		.tap (tx_tap.mon),
		.byte_count (produced_bytes),
		.pkt_count (tx_pkt_count)
	);

endmodule

//--- verif/tcp_bench_role_chk.sv
// ==================================================
// tcp benchmark role protocol checks
// run_tx, open request and done rules
// ==================================================
`timescale 1ns/1ps

module tcp_bench_role_chk (
	input logic ap_clk,
	input logic ap_rst_n,
	input logic ap_start,
	input logic is_server,
	input logic ap_done,
	input logic ap_idle,
	input logic run_tx,
	input logic open_conn_tvalid
);

	int fail_count = 0; // read by the testbench at the end
	logic started; // a start since reset

	always_ff @(posedge ap_clk) begin
		if (!ap_rst_n) begin
			started <= 1'b0;
		end else if (ap_start) begin
			started <= 1'b1;
		end
	end

	a_run_tx_single: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
		run_tx |=> !run_tx)
	else begin
		$error("run_tx high two cycles in a row");
		fail_count++;
	end

	a_no_server_req: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
		is_server |-> !open_conn_tvalid)
	else begin
		$error("open request in server mode");
		fail_count++;
	end

	a_done_idle: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
		ap_done |-> ap_idle)
	else begin
		$error("ap_done without ap_idle");
		fail_count++;
	end

	a_no_early_done: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
		!started |-> !ap_done)
	else begin
		$error("ap_done before any start");
		fail_count++;
	end

endmodule

//--- verif/tcp_bench_role_tb.sv
// ==================================================
// tcp benchmark role testbench
// client and server runs with random stream traffic
// ==================================================
`timescale 1ns/1ps
`include "bench_settings.svh"

module tcp_bench_role_tb;

	localparam int MAX_CYCLES = 3000; // two runs of a few hundred cycles each, wide margin

	logic ap_clk;
	logic ap_rst_n;
	logic ap_start;
	logic is_server;
	bench_pkg::xfer_size_t transfer_size;
	logic [`BENCH_IP_W-1:0] base_ip;
	logic [`BENCH_PORT_W-1:0] base_port;
	logic ap_done;
	logic ap_idle;
	logic open_conn_tvalid;
	logic open_conn_tready;
	tcp_msg_pkg::open_req_t open_conn_tdata;
	logic open_status_tvalid;
	logic open_status_tready;
	tcp_msg_pkg::open_status_t open_status_tdata;
	logic rx_meta_tvalid;
	logic rx_meta_tready;
	tcp_msg_pkg::session_t rx_meta_tdata;
	logic rx_data_tvalid;
	logic rx_data_tready;
	logic [`BENCH_KEEP_W-1:0] rx_data_tkeep;
	logic rx_data_tlast;
	logic tx_data_tvalid;
	logic tx_data_tready;
	logic [`BENCH_KEEP_W-1:0] tx_data_tkeep;
	logic tx_data_tlast;
	logic tx_status_tvalid;
	logic tx_status_tready;
	tcp_msg_pkg::tx_status_t tx_status_tdata;
	logic run_tx;
	tcp_msg_pkg::session_t session_id;
	bench_pkg::byte_count_t consumed_bytes;
	bench_pkg::byte_count_t produced_bytes;
	bench_pkg::event_count_t rx_pkt_count;
	bench_pkg::event_count_t tx_pkt_count;
	bench_pkg::cycle_count_t execution_cycles;
	bench_pkg::cycle_count_t open_con_cycles;
	bench_pkg::event_count_t tx_sts_count;
	bench_pkg::event_count_t tx_sts_good_count;

	// expected statistics, built from accepted beats
	bench_pkg::byte_count_t exp_rx;
	bench_pkg::byte_count_t exp_tx;
	bench_pkg::event_count_t exp_rx_pkt;
	bench_pkg::event_count_t exp_tx_pkt;
	bench_pkg::event_count_t exp_sts;
	bench_pkg::event_count_t exp_sts_good;
	bench_pkg::cycle_count_t exp_exec; // running cycles of this run
	logic exp_running; // modeled run state
	logic start_q; // ap_start seen at last edge
	integer seed = 32'h8ec6131f;
	int setup_n; // running cycles before the open succeeds
	int cycle_n = 0;

	tcp_bench_role i_tcp_bench_role (.*);

	bind tcp_bench_role tcp_bench_role_chk u_chk (.*);

	initial begin
		ap_clk = 1'b0;
		forever #20 ap_clk = ~ap_clk;
	end

	// number of enabled bytes in a keep mask
	function automatic int bytes_of_keep(input logic [`BENCH_KEEP_W-1:0] keep);
		int n;
		n = 0;
		for (int i = 0; i < `BENCH_KEEP_W; i++) begin
			n += keep[i];
		end
		return n;
	endfunction

	task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
		input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t ns %s got %0h expected %0h", $time, what, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic next_cycle;
		@(posedge ap_clk);
		#2;
	endtask

	task automatic idle_streams;
		rx_data_tvalid = 1'b0;
		rx_data_tready = 1'b0;
		rx_data_tkeep = '0;
		rx_data_tlast = 1'b0;
		tx_data_tvalid = 1'b0;
		tx_data_tready = 1'b0;
		tx_data_tkeep = '0;
		tx_data_tlast = 1'b0;
		tx_status_tvalid = 1'b0;
		tx_status_tready = 1'b0;
		tx_status_tdata = '0;
	endtask

	// random beats until the chosen directions reach transfer_size
	task automatic stream_until_size(input bit rx_on, input bit tx_on);
		logic [31:0] r;
		while ((rx_on && exp_rx < transfer_size) || (tx_on && exp_tx < transfer_size)) begin
			r = $random(seed);
			rx_data_tvalid = rx_on & r[0];
			rx_data_tready = r[1] | r[2]; // gap a quarter of the time
			rx_data_tkeep = {`BENCH_KEEP_W{1'b1}} >> r[5:3]; // 1 to 8 bytes
			rx_data_tlast = r[6];
			tx_data_tvalid = tx_on & r[8];
			tx_data_tready = r[9] | r[10];
			tx_data_tkeep = {`BENCH_KEEP_W{1'b1}} >> r[13:11];
			tx_data_tlast = r[14];
			tx_status_tvalid = r[16];
			tx_status_tready = r[17] | r[18];
			tx_status_tdata.error = r[20:19]; // good one time in four
			tx_status_tdata.info = {r, r[29:0]};
			next_cycle();
			check_value(run_tx, 1'b0, "run_tx while streaming");
		end
		idle_streams();
	endtask

	task automatic start_run;
		ap_start = 1'b1;
		#1;
		check_value(open_conn_tvalid, !is_server, "open request valid");
		if (!is_server) begin
			check_value(open_conn_tdata, {base_port, base_ip}, "open request data");
		end
		next_cycle();
		ap_start = 1'b0;
		check_value(open_conn_tvalid, 1'b0, "open request single cycle");
		check_value(ap_done, 1'b0, "ap_done after start");
		check_value(ap_idle, 1'b0, "ap_idle after start");
		check_value(session_id, '0, "session_id after start");
		check_value(execution_cycles, '0, "execution_cycles after start");
		check_value(open_con_cycles, '0, "open_con_cycles after start");
		check_value(tx_sts_count, '0, "tx_sts_count after start");
	endtask

	// both sizes were counted at the last edge
	task automatic expect_finish;
		bench_pkg::cycle_count_t snap;
		check_value(ap_done, 1'b0, "ap_done before finish");
		next_cycle();
		check_value(ap_done, 1'b1, "ap_done at finish");
		check_value(ap_idle, 1'b1, "ap_idle at finish");
		snap = execution_cycles;
		repeat (5) next_cycle();
		check_value(execution_cycles, snap, "execution_cycles after finish");
		check_value(ap_done, 1'b1, "ap_done held");
		check_value(ap_idle, 1'b1, "ap_idle held");
	endtask

	// model of the statistics, one update per edge
	always @(posedge ap_clk) begin
		if (!ap_rst_n || (ap_start && !start_q)) begin
			exp_running = ap_rst_n; // a start begins a run
			exp_exec = '0;
			exp_rx = '0;
			exp_tx = '0;
			exp_rx_pkt = '0;
			exp_tx_pkt = '0;
			exp_sts = '0;
			exp_sts_good = '0;
		end else begin
			if (exp_running) begin
				exp_exec++;
				if (exp_rx >= transfer_size && exp_tx >= transfer_size) begin
					exp_running = 1'b0; // last running cycle
				end
			end
			if (rx_data_tvalid && rx_data_tready) begin
				exp_rx += bytes_of_keep(rx_data_tkeep);
				exp_rx_pkt += rx_data_tlast;
			end
			if (tx_data_tvalid && tx_data_tready) begin
				exp_tx += bytes_of_keep(tx_data_tkeep);
				exp_tx_pkt += tx_data_tlast;
			end
			if (tx_status_tvalid && tx_status_tready) begin
				exp_sts++;
				exp_sts_good += (tx_status_tdata.error == '0);
			end
		end
		start_q = ap_rst_n & ap_start;
	end

	// compare mid cycle, away from both edges
	always @(negedge ap_clk) begin
		if (ap_rst_n) begin
			check_value(consumed_bytes, exp_rx, "consumed_bytes");
			check_value(produced_bytes, exp_tx, "produced_bytes");
			check_value(rx_pkt_count, exp_rx_pkt, "rx_pkt_count");
			check_value(tx_pkt_count, exp_tx_pkt, "tx_pkt_count");
			check_value(tx_sts_count, exp_sts, "tx_sts_count");
			check_value(tx_sts_good_count, exp_sts_good, "tx_sts_good_count");
			check_value(execution_cycles, exp_exec, "execution_cycles");
		end
	end

	always @(posedge ap_clk) begin
		cycle_n++;
		if (cycle_n == MAX_CYCLES) begin
			$display("run did not finish within %0d cycles", MAX_CYCLES);
			$display("=== FAIL ===");
			$fatal(1, "timeout");
		end
	end

	initial begin
		ap_start = 1'b0;
		is_server = 1'b0;
		transfer_size = 200;
		base_ip = 32'hc0a8_0a02;
		base_port = 16'd5001;
		open_conn_tready = 1'b1;
		open_status_tvalid = 1'b0;
		open_status_tdata = '0;
		rx_meta_tvalid = 1'b0;
		rx_meta_tready = 1'b0;
		rx_meta_tdata = '0;
		idle_streams();
		ap_rst_n = 1'b0;
		repeat (4) @(posedge ap_clk);
		#2;
		ap_rst_n = 1'b1;
		check_value(ap_idle, 1'b1, "ap_idle after reset");
		check_value(ap_done, 1'b0, "ap_done after reset");
		check_value(run_tx, 1'b0, "run_tx after reset");
		check_value(execution_cycles, '0, "execution_cycles after reset");
		check_value(open_status_tready, 1'b1, "open_status_tready held high");

		// client run
		start_run();
		setup_n = 0;
		repeat (3) begin
			next_cycle(); // stack still opening
			setup_n++;
		end
		open_status_tvalid = 1'b1;
		open_status_tdata.success = 1'b0;
		open_status_tdata.session = 16'hdead;
		next_cycle();
		setup_n++;
		check_value(session_id, '0, "session_id after failed open");
		check_value(run_tx, 1'b0, "run_tx after failed open");
		open_status_tdata.success = 1'b1;
		open_status_tdata.session = 16'h0042;
		next_cycle();
		setup_n++;
		open_status_tvalid = 1'b0;
		check_value(session_id, 16'h0042, "client session_id");
		check_value(run_tx, 1'b1, "client run_tx");
		check_value(open_con_cycles, setup_n, "open_con_cycles");
		next_cycle();
		check_value(run_tx, 1'b0, "client run_tx single");
		open_status_tvalid = 1'b1; // repeated success, no second pulse
		next_cycle();
		open_status_tvalid = 1'b0;
		check_value(run_tx, 1'b0, "run_tx after second open");
		stream_until_size(1'b1, 1'b1);
		expect_finish();

		// server run, also a restart of the role
		is_server = 1'b1;
		transfer_size = 150;
		next_cycle();
		start_run();
		rx_meta_tvalid = 1'b1;
		rx_meta_tready = 1'b1;
		rx_meta_tdata = 16'h1234;
		next_cycle();
		rx_meta_tvalid = 1'b0;
		check_value(session_id, 16'h1234, "server session_id");
		stream_until_size(1'b1, 1'b0);
		next_cycle();
		check_value(run_tx, 1'b1, "server run_tx");
		next_cycle();
		check_value(run_tx, 1'b0, "server run_tx single");
		stream_until_size(1'b0, 1'b1);
		expect_finish();

		next_cycle();
		if (i_tcp_bench_role.u_chk.fail_count == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			$display("protocol assertions reported failures");
			$display("=== FAIL ===");
			$fatal(1, "assertion failures");
		end
	end

endmodule

//--- tcp_bench_role.f
+incdir+common
common/tcp_msg_pkg.sv
common/bench_pkg.sv
common/beat_tap_if.sv
hdl/byte_meter.sv
status/conn_status_tracker.sv
control/experiment_ctrl.sv
hdl/tcp_bench_role.sv
verif/tcp_bench_role_chk.sv
verif/tcp_bench_role_tb.sv

//--- Bender.yml
package:
  name: tcp_bench_role

sources:
  - include_dirs:
      - common
    files:
      - common/tcp_msg_pkg.sv
      - common/bench_pkg.sv
      - common/beat_tap_if.sv
      - hdl/byte_meter.sv
      - status/conn_status_tracker.sv
      - control/experiment_ctrl.sv
      - hdl/tcp_bench_role.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/tcp_bench_role_chk.sv
      - verif/tcp_bench_role_tb.sv
